/* Makefile */
VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= soc_bus.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* logic/baud_timer.sv */
`timescale 1ns/100ps

module baud_timer (
    input  logic        pll_clk,
    input  logic        reset,
    input  logic [15:0] divisor,
    input  logic        tx_restart,
    input  logic        rx_restart,
    output logic [1:0]  bit_tick,    // {receive, transmit}
    output logic        half_tick
);

    logic [15:0] tx_count;
    logic [15:0] rx_count;

    // a bit lasts divisor + 1 clocks, from reload down to zero
    assign bit_tick[0] = (tx_count == 16'h0);
    assign bit_tick[1] = (rx_count == 16'h0);

    // halfway down the receive count is the middle of the bit
    assign half_tick = (rx_count == {1'b0, divisor[15:1]});

    // ##################################################################
    // down-counters
    // ##################################################################

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            tx_count <= 16'h0;
            rx_count <= 16'h0;
        end else begin
            if (tx_restart || bit_tick[0]) begin
                tx_count <= divisor;
            end else begin
                tx_count <= tx_count - 16'h1;
            end

            // restart on the falling edge lines the count up with the frame
            if (rx_restart || bit_tick[1]) begin
                rx_count <= divisor;
            end else begin
                rx_count <= rx_count - 16'h1;
            end
        end
    end

endmodule

/* logic/ram.sv */
`timescale 1ns/100ps

module ram import soc_pkg::*; #(
    parameter int RAM_WORDS = 16384
) (
    input  logic        pll_clk,
    input  logic        sel,
    input  mem_bus_t    bus,
    output logic [31:0] read_value
);

    localparam int INDEX_BITS = $clog2(RAM_WORDS);

    logic [31:0]           mem [RAM_WORDS];
    logic [INDEX_BITS-1:0] index;

    // word address, the two byte bits below it are ignored
    assign index = bus.address[INDEX_BITS+1:2];

    // ##################################################################
    // byte-masked write
    // ##################################################################

    always_ff @(posedge pll_clk) begin
        if (sel) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.write_mask[lane]) begin
                    mem[index][lane*8 +: 8] <= bus.write_value[lane*8 +: 8];
                end
            end
        end
    end

    // ##################################################################
    // registered read
    // ##################################################################

    // unselected cycles return zero so the top can OR all devices together
    always_ff @(posedge pll_clk) begin
        if (sel && bus.read) begin
            read_value <= mem[index];
        end else begin
            read_value <= 32'h0;
        end
    end

endmodule

/* logic/soc_pkg.sv */
package soc_pkg;

    // one request from the core's memory bus, valid for a single cycle
    typedef struct packed {
        logic        read;
        logic [3:0]  write_mask;
        logic [31:0] address;
        logic [31:0] write_value;
    } mem_bus_t;

    // ##################################################################
    // address map
    // ##################################################################

    localparam logic [31:0] RAM_BASE  = 32'h0000_0000;  // 64 KiB window
    localparam logic [31:0] LEDS_BASE = 32'h0001_0000;  // one word
    localparam logic [31:0] UART_BASE = 32'h0002_0000;  // four words

    // ##################################################################
    // uart registers
    // ##################################################################

    // word offsets inside the uart window
    localparam logic [1:0] UART_DATA    = 2'd0;
    localparam logic [1:0] UART_STATUS  = 2'd1;
    localparam logic [1:0] UART_DIVISOR = 2'd2;

    // bit positions in the status word
    localparam int STATUS_TX_BUSY    = 0;
    localparam int STATUS_RX_VALID   = 1;
    localparam int STATUS_RX_OVERRUN = 2;

    // frame sequencer states, shared by the transmit and receive sides
    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } uart_state_t;

endpackage

/* logic/soc_top.sv */
`timescale 1ns/100ps

module soc_top import soc_pkg::*; #(
    parameter int RAM_WORDS       = 16384,
    parameter int DEFAULT_DIVISOR = 7
) (
    input  logic        pll_clk,
    input  logic        reset,

    // memory bus from the core
    input  logic        mem_read,
    input  logic [3:0]  mem_write_mask,
    input  logic [31:0] mem_address,
    input  logic [31:0] mem_write_value,
    output logic [31:0] mem_read_value,

    output logic [7:0]  leds,

    input  logic        uart_rx,
    output logic        uart_tx
);

    mem_bus_t    bus;
    logic        ram_sel;
    logic        leds_sel;
    logic        uart_sel;
    logic [31:0] ram_read_value;
    logic [31:0] leds_read_value;
    logic [31:0] uart_read_value;

    assign bus = '{
        read:        mem_read,
        write_mask:  mem_write_mask,
        address:     mem_address,
        write_value: mem_write_value
    };

    // ##################################################################
    // address decode
    // ##################################################################

    // the three windows never overlap, so at most one select is high
    always_comb begin
        ram_sel  = (bus.address[31:16] == RAM_BASE[31:16]);
        leds_sel = (bus.address[31:2] == LEDS_BASE[31:2]);
        uart_sel = (bus.address[31:4] == UART_BASE[31:4]);
    end

    // every device returns zero unless it was read last cycle
    assign mem_read_value = ram_read_value | leds_read_value | uart_read_value;

    // ##################################################################
    // LED register
    // ##################################################################

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            leds <= 8'h00;
        end else if (leds_sel && bus.write_mask[0]) begin
            leds <= bus.write_value[7:0];  // only byte lane 0 is wired
        end
    end

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            leds_read_value <= 32'h0;
        end else if (leds_sel && bus.read) begin
            leds_read_value <= {24'h0, leds};
        end else begin
            leds_read_value <= 32'h0;
        end
    end

    // ##################################################################
    // devices
    // ##################################################################

    ram #(
        .RAM_WORDS(RAM_WORDS)
    ) ram (
        .pll_clk(pll_clk),
        .sel(ram_sel),
        .bus(bus),
        .read_value(ram_read_value)
    );

    uart #(
        .DEFAULT_DIVISOR(DEFAULT_DIVISOR)
    ) uart (
        .pll_clk(pll_clk),
        .reset(reset),
        .sel(uart_sel),
        .bus(bus),
        .read_value(uart_read_value),
        .rx(uart_rx),
        .tx(uart_tx)
    );

endmodule

/* logic/uart.sv */
`timescale 1ns/100ps

module uart import soc_pkg::*; #(
    parameter int DEFAULT_DIVISOR = 7
) (
    input  logic        pll_clk,
    input  logic        reset,
    input  logic        sel,
    input  mem_bus_t    bus,
    output logic [31:0] read_value,
    input  logic        rx,
    output logic        tx
);

    logic [1:0]  offset;
    logic        bus_write;
    logic        bus_read;
    logic        tx_start;
    logic [15:0] divisor;
    logic [8:0]  tx_shreg;      // data bits followed by the stop bit
    logic [7:0]  rx_shreg;
    logic [7:0]  rx_data;
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_valid;
    logic        rx_overrun;
    logic [31:0] status;
    logic        tx_load;
    logic        tx_shift;
    logic        tx_restart;
    logic        rx_restart;
    logic        rx_sample;
    logic        rx_done;
    logic        tx_busy;
    logic [1:0]  bit_tick;
    logic        half_tick;

    assign offset    = bus.address[3:2];
    assign bus_write = sel && (bus.write_mask != 4'h0);
    assign bus_read  = sel && bus.read;
    assign tx_start  = bus_write && offset == UART_DATA && bus.write_mask[0];

    always_comb begin
        status                    = 32'h0;
        status[STATUS_TX_BUSY]    = tx_busy;
        status[STATUS_RX_VALID]   = rx_valid;
        status[STATUS_RX_OVERRUN] = rx_overrun;
    end

    // ##################################################################
    // registers
    // ##################################################################

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            divisor    <= 16'(DEFAULT_DIVISOR);
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
            read_value <= 32'h0;
        end else begin
            if (bus_write && offset == UART_DIVISOR) begin
                if (bus.write_mask[0]) divisor[7:0] <= bus.write_value[7:0];
                if (bus.write_mask[1]) divisor[15:8] <= bus.write_value[15:8];
            end
            // overrun is write-one-to-clear
            if (bus_write && offset == UART_STATUS && bus.write_mask[0]
                    && bus.write_value[STATUS_RX_OVERRUN]) begin
                rx_overrun <= 1'b0;
            end
            if (bus_read && offset == UART_DATA) rx_valid <= 1'b0;
            if (rx_done) begin
                rx_valid <= 1'b1;  // a new frame wins over a read in the same cycle
                if (rx_valid) rx_overrun <= 1'b1;
            end

            read_value <= 32'h0;
            if (bus_read) begin
                case (offset)
                    UART_DATA:    read_value <= {24'h0, rx_data};
                    UART_STATUS:  read_value <= status;
                    UART_DIVISOR: read_value <= {16'h0, divisor};
                    default:      read_value <= 32'h0;
                endcase
            end
        end
    end

    // ##################################################################
    // serial datapath
    // ##################################################################

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            tx      <= 1'b1;
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            if (tx_load) begin
                tx <= 1'b0;  // start bit
            end else if (tx_shift) begin
                tx <= tx_shreg[0];
            end
        end
    end

    // payload shifters, steered entirely by the sequencer
    always_ff @(posedge pll_clk) begin
        if (tx_load) tx_shreg <= {1'b1, bus.write_value[7:0]};
        else if (tx_shift) tx_shreg <= {1'b1, tx_shreg[8:1]};
        if (rx_sample) rx_shreg <= {rx_sync, rx_shreg[7:1]};  // lsb arrives first
        if (rx_done) rx_data <= rx_shreg;
    end

    uart_fsm uart_fsm (
        .pll_clk(pll_clk),
        .reset(reset),
        .tx_start(tx_start),
        .rx_line(rx_sync),
        .bit_tick(bit_tick),
        .half_tick(half_tick),
        .tx_load(tx_load),
        .tx_shift(tx_shift),
        .tx_restart(tx_restart),
        .rx_restart(rx_restart),
        .rx_sample(rx_sample),
        .rx_done(rx_done),
        .tx_busy(tx_busy)
    );

    baud_timer baud_timer (
        .pll_clk(pll_clk),
        .reset(reset),
        .divisor(divisor),
        .tx_restart(tx_restart),
        .rx_restart(rx_restart),
        .bit_tick(bit_tick),
        .half_tick(half_tick)
    );

endmodule

/* logic/uart_fsm.sv */
`timescale 1ns/100ps

module uart_fsm import soc_pkg::*; (
    input  logic       pll_clk,
    input  logic       reset,
    input  logic       tx_start,
    input  logic       rx_line,
    input  logic [1:0] bit_tick,   // bit 0 transmit, bit 1 receive
    input  logic       half_tick,
    output logic       tx_load,
    output logic       tx_shift,
    output logic       tx_restart,
    output logic       rx_restart,
    output logic       rx_sample,
    output logic       rx_done,
    output logic       tx_busy
);

    uart_state_t tx_state;
    uart_state_t rx_state;
    logic [2:0]  tx_count;
    logic [2:0]  rx_count;
    logic        rx_prev;

    assign tx_busy    = (tx_state != idle);
    assign tx_restart = tx_load;  // bit timing starts with the start bit

    // ##################################################################
    // commands to the datapath
    // ##################################################################

    always_comb begin
        tx_load    = 1'b0;
        tx_shift   = 1'b0;
        rx_restart = 1'b0;
        rx_sample  = 1'b0;
        rx_done    = 1'b0;

        case (tx_state)
            idle:        tx_load = tx_start;  // writes while busy are dropped here
            start, data: tx_shift = bit_tick[0];
            default:     ;
        endcase

        case (rx_state)
            idle:    rx_restart = rx_prev && !rx_line;
            data:    rx_sample = half_tick;
            stop:    rx_done = half_tick;
            default: ;
        endcase
    end

    // ##################################################################
    // sequencers
    // ##################################################################

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            tx_state <= idle;
            rx_state <= idle;
            tx_count <= 3'd0;
            rx_count <= 3'd0;
            rx_prev  <= 1'b1;
        end else begin
            rx_prev <= rx_line;

            case (tx_state)
                idle: if (tx_load) tx_state <= start;
                start: begin
                    if (bit_tick[0]) begin
                        tx_state <= data;
                        tx_count <= 3'd0;
                    end
                end
                data: begin
                    if (bit_tick[0]) begin
                        tx_count <= tx_count + 3'd1;
                        if (tx_count == 3'd7) tx_state <= stop;  // last shift put out the stop bit
                    end
                end
                stop: if (bit_tick[0]) tx_state <= idle;
            endcase

            case (rx_state)
                idle: if (rx_restart) rx_state <= start;
                start: begin
                    // a glitch that is high again at mid-bit is not a start bit
                    if (half_tick && rx_line) begin
                        rx_state <= idle;
                    end else if (bit_tick[1]) begin
                        rx_state <= data;
                        rx_count <= 3'd0;
                    end
                end
                data: begin
                    if (bit_tick[1]) begin
                        rx_count <= rx_count + 3'd1;
                        if (rx_count == 3'd7) rx_state <= stop;
                    end
                end
                stop: if (half_tick) rx_state <= idle;
            endcase
        end
    end

endmodule

/* sim/soc_tb.sv */
`timescale 1ns/100ps

module soc_tb import soc_pkg::*; ();

    localparam int RAM_WORDS    = 16384;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_DIVISOR  = 15;                       // largest divisor in the test data
    localparam int FRAME_CYCLES = 10 * (MAX_DIVISOR + 1);  // a start bit, 8 data bits and a stop bit
    localparam int POLL_LIMIT   = 4 * FRAME_CYCLES;
    localparam int RANDOM_OPS   = 200;
    localparam int MAX_OPS      = 64;

    // operation codes in the first column of the test data
    localparam logic [31:0] OP_END   = 32'd0;
    localparam logic [31:0] OP_WRITE = 32'd1;
    localparam logic [31:0] OP_READ  = 32'd2;
    localparam logic [31:0] OP_POLL  = 32'd3;
    localparam logic [31:0] OP_START = 32'd4;
    localparam logic [31:0] OP_LEDS  = 32'd5;

    logic        pll_clk = 1'b0;
    logic        reset;
    logic        mem_read;
    logic [3:0]  mem_write_mask;
    logic [31:0] mem_address;
    logic [31:0] mem_write_value;
    logic [31:0] mem_read_value;
    logic [7:0]  leds;
    logic        uart_rx;
    logic        uart_tx;

    logic [31:0] test_words [MAX_OPS * 5];  // five columns per operation
    logic [31:0] ram_model [RAM_WORDS];
    int          op_count;
    logic        file_loaded = 1'b0;
    integer      seed;

    always #50 pll_clk = ~pll_clk;

    // serial loopback that stays idle high until the transmitter leaves reset
    always_comb uart_rx = (uart_tx === 1'b0) ? 1'b0 : 1'b1;

    soc_top #(
        .RAM_WORDS(RAM_WORDS),
        .DEFAULT_DIVISOR(7)
    ) uut (
        .pll_clk(pll_clk),
        .reset(reset),
        .mem_read(mem_read),
        .mem_write_mask(mem_write_mask),
        .mem_address(mem_address),
        .mem_write_value(mem_write_value),
        .mem_read_value(mem_read_value),
        .leds(leds),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx)
    );

    // ##################################################################
    // reporting
    // ##################################################################

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0d ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, actual, expected));
        end
    endtask

    // ##################################################################
    // bus operations
    // ##################################################################

    // drives one cycle from one falling edge to the next
    task automatic bus_cycle(input logic do_read, input logic [3:0] mask,
                             input logic [31:0] address, input logic [31:0] value,
                             output logic [31:0] result);
        mem_read        = do_read;
        mem_write_mask  = mask;
        mem_address     = address;
        mem_write_value = value;
        @(negedge pll_clk);
        result          = mem_read_value;  // registered at the rising edge in between
        mem_read        = 1'b0;
        mem_write_mask  = 4'h0;
        mem_address     = 32'hffff_fff0;
        mem_write_value = 32'h0;
    endtask

    task automatic poll_until(input logic [31:0] address, input logic [31:0] mask,
                              input logic [31:0] expected);
        logic [31:0] value;
        int          tries;
        tries = 0;
        bus_cycle(1'b1, 4'h0, address, 32'h0, value);
        while ((value & mask) !== expected) begin
            if (tries == POLL_LIMIT) begin
                abort_run($sformatf("polling 0x%08h never returned 0x%08h under mask 0x%08h",
                                    address, expected, mask));
            end
            bus_cycle(1'b1, 4'h0, address, 32'h0, value);
            tries++;
        end
    endtask

    // the byte must have bit 0 set so the start bit is the only low stretch
    task automatic measure_start_bit(input logic [31:0] address, input logic [3:0] mask,
                                     input logic [31:0] value, input logic [31:0] expected);
        logic [31:0] status;
        int          low_cycles;
        low_cycles = 0;
        bus_cycle(1'b0, mask, address, value, status);
        while (uart_tx == 1'b0) begin
            if (low_cycles > FRAME_CYCLES) begin
                abort_run("uart_tx stayed low longer than a whole frame");
            end
            low_cycles++;
            @(negedge pll_clk);
        end
        check_value("start bit length", low_cycles, expected);
        bus_cycle(1'b1, 4'h0, UART_BASE | {28'h0, UART_STATUS, 2'b00}, 32'h0, status);
        check_value("tx_busy", {31'h0, status[STATUS_TX_BUSY]}, 32'h1);
    endtask

    // ##################################################################
    // test phases
    // ##################################################################

    task automatic run_file();
        logic [31:0] op;
        logic [31:0] address;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] expected;
        logic [31:0] result;
        for (int n = 0; n < op_count; n++) begin
            op       = test_words[n * 5];
            address  = test_words[n * 5 + 1];
            mask     = test_words[n * 5 + 2];
            value    = test_words[n * 5 + 3];
            expected = test_words[n * 5 + 4];
            case (op)
                OP_WRITE: bus_cycle(1'b0, mask[3:0], address, value, result);
                OP_READ: begin
                    bus_cycle(1'b1, 4'h0, address, 32'h0, result);
                    check_value("mem_read_value", result & mask, expected);
                end
                OP_POLL:  poll_until(address, mask, expected);
                OP_START: measure_start_bit(address, mask[3:0], value, expected);
                OP_LEDS:  check_value("leds", {24'h0, leds}, expected);
                default: begin
                    abort_run($sformatf("test data entry %0d has an unknown operation %h",
                                        n, op));
                end
            endcase
        end
    endtask

    task automatic random_ram_traffic();
        int unsigned index;
        int unsigned pick;
        logic [31:0] value;
        logic [31:0] result;
        int unsigned written_q [$];
        for (int n = 0; n < RANDOM_OPS; n++) begin
            index = $random(seed) & (RAM_WORDS - 1);
            value = $random(seed);
            bus_cycle(1'b0, 4'hf, RAM_BASE + index * 4, value, result);
            ram_model[index] = value;
            written_q.push_back(index);
            // read back any word written so far and not only the newest one
            pick = written_q[{$random(seed)} % written_q.size()];
            bus_cycle(1'b1, 4'h0, RAM_BASE + pick * 4, 32'h0, result);
            check_value("mem_read_value", result, ram_model[pick]);
        end
    endtask

    // ##################################################################
    // main sequence and watchdog
    // ##################################################################

    initial begin
        seed            = 32'hc609;
        reset           = 1'b1;
        mem_read        = 1'b0;
        mem_write_mask  = 4'h0;
        mem_address     = 32'hffff_fff0;
        mem_write_value = 32'h0;

        $readmemh("sim/soc_testdata.txt", test_words);
        op_count = 0;
        while (op_count < MAX_OPS && test_words[op_count * 5] !== OP_END) op_count++;
        file_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge pll_clk);
        @(negedge pll_clk);
        reset = 1'b0;
        check_value("uart_tx", {31'h0, uart_tx}, 32'h1);
        check_value("mem_read_value", mem_read_value, 32'h0);

        run_file();
        random_ram_traffic();

        $display("Verification passed");
        $finish;
    end

    initial begin
        int limit;
        wait (file_loaded);
        limit = RESET_CYCLES + op_count * 40 * FRAME_CYCLES + RANDOM_OPS * 4;
        repeat (limit) @(posedge pll_clk);
        abort_run($sformatf("watchdog expired after %0d clock cycles", limit));
    end

endmodule

/* sim/soc_testdata.txt */
// op address mask write_value expected, all hex, one operation per line
// op 1 write, 2 read, 3 poll masked read, 4 start bit cycles, 5 leds, 0 end
2 00020008 ffffffff 00000000 00000007
2 00020004 ffffffff 00000000 00000000
2 00010000 ffffffff 00000000 00000000
5 00000000 00000000 00000000 00000000
1 00000010 f 11223344 00000000
1 00000010 1 000000aa 00000000
2 00000010 ffffffff 00000000 112233aa
1 00000010 6 bbccdd00 00000000
2 00000010 ffffffff 00000000 11ccddaa
1 00000010 8 ee000000 00000000
2 00000010 ffffffff 00000000 eeccddaa
1 0000fffc 3 cafef00d 00000000
2 0000fffc 0000ffff 00000000 0000f00d
1 00010000 1 123456a5 00000000
5 00000000 00000000 00000000 000000a5
2 00010000 ffffffff 00000000 000000a5
1 00010000 e ffffff00 00000000
5 00000000 00000000 00000000 000000a5
2 00010000 ffffffff 00000000 000000a5
1 00030000 f deadbeef 00000000
2 00030000 ffffffff 00000000 00000000
2 00010004 ffffffff 00000000 00000000
2 0002000c ffffffff 00000000 00000000
2 00020010 ffffffff 00000000 00000000
1 00020000 1 000000a5 00000000
3 00020004 00000002 00000000 00000002
2 00020000 ffffffff 00000000 000000a5
3 00020004 00000001 00000000 00000000
2 00020004 ffffffff 00000000 00000000
1 00020008 3 0000000f 00000000
2 00020008 ffffffff 00000000 0000000f
4 00020000 1 00000055 00000010
3 00020004 00000002 00000000 00000002
2 00020000 ffffffff 00000000 00000055
3 00020004 00000001 00000000 00000000
1 00020008 3 00000007 00000000
1 00020000 1 0000003c 00000000
3 00020004 00000002 00000000 00000002
3 00020004 00000001 00000000 00000000
1 00020000 1 000000c3 00000000
3 00020004 00000004 00000000 00000004
1 00020004 1 00000004 00000000
2 00020004 00000006 00000000 00000002
2 00020000 ffffffff 00000000 000000c3
3 00020004 00000001 00000000 00000000
2 00020004 ffffffff 00000000 00000000
0 00000000 00000000 00000000 00000000

/* soc_bus.f */
logic/soc_pkg.sv
logic/baud_timer.sv
logic/uart_fsm.sv
logic/uart.sv
logic/ram.sv
logic/soc_top.sv
sim/soc_tb.sv
